//--- Makefile
SIM       := verilator
TOP       := pcSeqTb
FILELIST  := tb.f
OBJDIR    := obj_dir
SIMFLAGS  := --binary --timing -j 0 --Mdir $(OBJDIR) --top-module $(TOP)
LINTFLAGS := --lint-only --timing --top-module $(TOP)
PASSMSG   := STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIMFLAGS) -f $(FILELIST)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASSMSG)"

lint:
	$(SIM) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

//--- dv/pcSeqModel.svh
`ifndef PCSEQMODEL_SVH
`define PCSEQMODEL_SVH

// ##############################
// reference stack model.
// ##############################

pcWord_t     mdlPc;
pcWord_t     mdlStk[$];  // back of queue is the top.
logic        mdlOvf;
logic        mdlUnf;
logic [31:0] rngState;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

// state after the next clock edge.
task automatic predictStep(input logic valid, input seqOp_e op, input pcWord_t target,
                           input logic hold);
  pcWord_t inc;
  inc = mdlPc + pcWord_t'(1);
  if (valid) begin
    case (op)
      OP_NEXT: mdlPc = inc;
      OP_JUMP: mdlPc = target;
      OP_CALL: begin
        if (mdlStk.size() == `STK_DEPTH) mdlOvf = 1'b1;
        else if (!hold) mdlStk.push_back(inc);
        mdlPc = target;
      end
      OP_RET: begin
        if (mdlStk.size() == 0) begin
          mdlUnf = 1'b1;
          mdlPc = inc;
        end else begin
          mdlPc = mdlStk[mdlStk.size() - 1];
          if (!hold) void'(mdlStk.pop_back());
        end
      end
    endcase
  end
endtask

task automatic randomMix();
  logic [31:0] r;
  pcWord_t     top;
  pcWord_t     below;
  mdlPc = '0;
  mdlStk.delete();
  mdlOvf = 1'b0;
  mdlUnf = 1'b0;
  rngState = 32'd42;
  for (int n = 0; n < 200; n++) begin
    rngState = xorshift32(rngState);
    r = rngState;
    cmdValid = (r[4:2] != 3'd0);   // mostly valid.
    cmd.op = seqOp_e'(r[1:0]);
    cmd.target = r[21:8];
    stackHold = (r[7:5] == 3'd0);  // held about one cycle in eight.
    predictStep(cmdValid, cmd.op, cmd.target, stackHold);
    @(posedge PCSCLK);
    #2;
    top = '0;
    below = '0;
    if (mdlStk.size() > 0) top = mdlStk[mdlStk.size() - 1];
    if (mdlStk.size() > 1) below = mdlStk[mdlStk.size() - 2];
    checkState(mdlPc, mdlStk.size(), top, below, mdlOvf, mdlUnf);
  end
  cmdValid = 1'b0;
  stackHold = 1'b0;
endtask

`endif

//--- dv/pcSeqTb.sv
`include "dspSeq_params.svh"

module pcSeqTb
  import dspSeqPkg::*;
();

  typedef logic [`PC_W-1:0] pcWord_t;

  // one row of the directed table.
  typedef struct packed {
    logic [1:0] grp;
    logic       valid;
    seqOp_e     op;
    pcWord_t    target;
    logic       hold;
    pcWord_t    expPc;
    logic [4:0] expDepth;
    pcWord_t    expTop;
    pcWord_t    expBelow;
    logic       expOvf;
    logic       expUnf;
  } stepEntry_t;

  logic     PCSCLK;
  logic     T_RST;
  logic     cmdValid;
  seqCmd_t  cmd;
  logic     stackHold;
  pcWord_t  pc;
  stkStat_t stkStat;
  logic     ovfErr;
  logic     unfErr;

  stepEntry_t steps[$];
  string      grpName [4] = '{"next/jump/hold", "nested calls", "overflow", "underflow/hold"};
  logic       ovfNow;   // sticky flags expected while building rows.
  logic       unfNow;
  bit         tableBuilt;
  int         errCount;
  int         testsRun;
  int         testsFailed;
  int         errStart;

  pcSeqTop u_dut (
    .PCSCLK    (PCSCLK),
    .T_RST     (T_RST),
    .cmdValid  (cmdValid),
    .cmd       (cmd),
    .stackHold (stackHold),
    .pc        (pc),
    .stkStat   (stkStat),
    .ovfErr    (ovfErr),
    .unfErr    (unfErr)
  );

  always #10 PCSCLK = ~PCSCLK;

  // run length covers table rows, random cycles and both resets.
  initial begin
    wait (tableBuilt);
    #((steps.size() + 200 + 40) * 20);
    $display("Timeout: the tests did not finish within the cycle budget");
    $display("STATUS: FAIL");
    $finish;
  end

  // ##############################
  // checking and reporting.
  // ##############################

  task automatic flagError(input string msg);
    $display("Error at %0t: %s", $time, msg);
    errCount++;
  endtask

  task automatic checkState(input pcWord_t expPc, input int depth, input pcWord_t top,
                            input pcWord_t below, input logic ovf, input logic unf);
    if (pc !== expPc) flagError($sformatf("pc is %h, expected %h", pc, expPc));
    if (stkStat.empty !== (depth == 0)) flagError($sformatf("empty wrong at depth %0d", depth));
    if (stkStat.full !== (depth == 16)) flagError($sformatf("full wrong at depth %0d", depth));
    if (stkStat.hasOne !== (depth == 1)) flagError($sformatf("hasOne wrong at depth %0d", depth));
    if (depth > 0 && stkStat.topPc !== top)
      flagError($sformatf("topPc is %h, expected %h", stkStat.topPc, top));
    if (depth > 1 && stkStat.belowPc !== below)
      flagError($sformatf("belowPc is %h, expected %h", stkStat.belowPc, below));
    if (ovfErr !== ovf) flagError($sformatf("ovfErr is %b, expected %b", ovfErr, ovf));
    if (unfErr !== unf) flagError($sformatf("unfErr is %b, expected %b", unfErr, unf));
  endtask

  task automatic reportTest(input string name, input int errBefore);
    int n;
    n = errCount - errBefore;
    testsRun++;
    if (n != 0) testsFailed++;
    $display("test %s: %s, %0d errors", name, (n == 0) ? "ok" : "failed", n);
  endtask

  task automatic applyReset();
    T_RST = 1'b1;
    cmdValid = 1'b0;
    cmd = '0;
    stackHold = 1'b0;
    repeat (16) @(posedge PCSCLK);
    #2;
    T_RST = 1'b0;
  endtask

  // ##############################
  // directed table.
  // ##############################

  task automatic addStep(input int grp, input logic valid, input seqOp_e op,
                         input pcWord_t target, input logic hold, input pcWord_t expPc,
                         input int depth, input pcWord_t top, input pcWord_t below);
    stepEntry_t s;
    s = '{2'(grp), valid, op, target, hold, expPc, 5'(depth), top, below, ovfNow, unfNow};
    steps.push_back(s);
  endtask

  task automatic buildTable();
    pcWord_t pcNow;
    pcWord_t below;
    pcWord_t retAddr[$];
    ovfNow = 1'b0;
    unfNow = 1'b0;
    addStep(0, 1'b1, OP_NEXT, '0, 1'b0, 14'h0001, 0, '0, '0);
    addStep(0, 1'b1, OP_NEXT, '0, 1'b0, 14'h0002, 0, '0, '0);
    addStep(0, 1'b1, OP_JUMP, 14'h0100, 1'b0, 14'h0100, 0, '0, '0);
    addStep(0, 1'b0, OP_NEXT, '0, 1'b0, 14'h0100, 0, '0, '0);
    addStep(0, 1'b1, OP_NEXT, '0, 1'b0, 14'h0101, 0, '0, '0);
    addStep(0, 1'b0, OP_JUMP, 14'h03FF, 1'b0, 14'h0101, 0, '0, '0); // idle jump ignored.
    addStep(1, 1'b1, OP_CALL, 14'h0200, 1'b0, 14'h0200, 1, 14'h0102, '0);
    addStep(1, 1'b1, OP_NEXT, '0, 1'b0, 14'h0201, 1, 14'h0102, '0);
    addStep(1, 1'b1, OP_CALL, 14'h0300, 1'b0, 14'h0300, 2, 14'h0202, 14'h0102);
    addStep(1, 1'b1, OP_CALL, 14'h0400, 1'b0, 14'h0400, 3, 14'h0301, 14'h0202);
    addStep(1, 1'b1, OP_RET, '0, 1'b0, 14'h0301, 2, 14'h0202, 14'h0102);
    addStep(1, 1'b1, OP_RET, '0, 1'b0, 14'h0202, 1, 14'h0102, '0);
    addStep(1, 1'b1, OP_RET, '0, 1'b0, 14'h0102, 0, '0, '0);
    // fill all sixteen slots.
    addStep(2, 1'b1, OP_JUMP, 14'h0F00, 1'b0, 14'h0F00, 0, '0, '0);
    pcNow = 14'h0F00;
    for (int i = 0; i < 16; i++) begin
      retAddr.push_back(pcNow + pcWord_t'(1));
      pcNow = pcWord_t'(32'h1000 + i * 16);
      below = (i > 0) ? retAddr[i - 1] : '0;
      addStep(2, 1'b1, OP_CALL, pcNow, 1'b0, pcNow, i + 1, retAddr[i], below);
    end
    ovfNow = 1'b1;
    addStep(2, 1'b1, OP_CALL, 14'h2000, 1'b0, 14'h2000, 16, retAddr[15], retAddr[14]);
    for (int i = 15; i >= 0; i--) begin
      addStep(2, 1'b1, OP_RET, '0, 1'b0, retAddr[i], i, (i > 0) ? retAddr[i - 1] : '0,
              (i > 1) ? retAddr[i - 2] : '0);
    end
    unfNow = 1'b1;
    addStep(3, 1'b1, OP_RET, '0, 1'b0, 14'h0F02, 0, '0, '0);
    addStep(3, 1'b1, OP_CALL, 14'h0500, 1'b1, 14'h0500, 0, '0, '0); // held push.
    addStep(3, 1'b1, OP_CALL, 14'h0600, 1'b0, 14'h0600, 1, 14'h0501, '0);
    addStep(3, 1'b1, OP_RET, '0, 1'b1, 14'h0501, 1, 14'h0501, '0); // held pop.
    addStep(3, 1'b1, OP_JUMP, 14'h0700, 1'b0, 14'h0700, 1, 14'h0501, '0);
    addStep(3, 1'b1, OP_RET, '0, 1'b0, 14'h0501, 0, '0, '0);
  endtask

  task automatic runTable();
    stepEntry_t s;
    int groupStart;
    groupStart = errCount;
    foreach (steps[i]) begin
      s = steps[i];
      cmdValid = s.valid;
      cmd.op = s.op;
      cmd.target = s.target;
      stackHold = s.hold;
      @(posedge PCSCLK);
      #2;
      checkState(s.expPc, int'(s.expDepth), s.expTop, s.expBelow, s.expOvf, s.expUnf);
      if (i == steps.size() - 1 || steps[i + 1].grp != s.grp) begin
        reportTest(grpName[s.grp], groupStart);
        groupStart = errCount;
      end
    end
    cmdValid = 1'b0;
    stackHold = 1'b0;
  endtask

  `include "pcSeqModel.svh"

  // ##############################
  // test sequence.
  // ##############################

  initial begin
    PCSCLK = 1'b0;
    T_RST = 1'b1;
    cmdValid = 1'b0;
    cmd = '0;
    stackHold = 1'b0;
    buildTable();
    tableBuilt = 1'b1;
    applyReset();
    errStart = errCount;
    checkState('0, 0, '0, '0, 1'b0, 1'b0);
    reportTest("reset state", errStart);
    runTable();
    applyReset();
    errStart = errCount;
    randomMix();
    reportTest("random mix", errStart);
    $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errCount);
    if (errCount == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- hw/dspSeqPkg.sv
`include "dspSeq_params.svh"

package dspSeqPkg;

  // ##############################
  // sequencer commands.
  // ##############################

  typedef enum logic [1:0] {
    OP_NEXT = 2'd0, // pc + 1.
    OP_JUMP = 2'd1, // load target.
    OP_CALL = 2'd2, // push return address, load target.
    OP_RET  = 2'd3  // load top of stack, pop.
  } seqOp_e;

  typedef struct packed {
    seqOp_e           op;
    logic [`PC_W-1:0] target;
  } seqCmd_t;

  // ##############################
  // stack status.
  // ##############################

  typedef struct packed {
    logic [`PC_W-1:0] topPc;   // entry at pointer.
    logic [`PC_W-1:0] belowPc; // entry under it.
    logic             empty;
    logic             full;
    logic             hasOne;
  } stkStat_t;

endpackage

//--- hw/dspSeq_params.svh
`ifndef DSPSEQ_PARAMS_SVH
`define DSPSEQ_PARAMS_SVH

// ##############################
// sequencer sizing.
// ##############################

// program counter and stack entry width.
`define PC_W 14

// return stack depth.
`define STK_DEPTH 16

// stack address width; pointer carries one extra bit for empty.
`define STK_AW 4

`endif

//--- hw/pcSeqTop.sv
`include "dspSeq_params.svh"

module pcSeqTop
  import dspSeqPkg::*;
(
  input  logic             PCSCLK,
  input  logic             T_RST,
  input  logic             cmdValid,
  input  seqCmd_t          cmd,
  input  logic             stackHold,
  output logic [`PC_W-1:0] pc,
  output stkStat_t         stkStat,
  output logic             ovfErr,
  output logic             unfErr
);

  // sequencer to stack.
  logic             pushReq;
  logic             popReq;
  logic [`PC_W-1:0] pushData;

  // ##############################
  // program sequencer.
  // ##############################

  pcSequencer uSeq (
    .PCSCLK   (PCSCLK),
    .T_RST    (T_RST),
    .cmdValid (cmdValid),
    .cmd      (cmd),
    .stkStat  (stkStat),
    .pc       (pc),
    .pushReq  (pushReq),
    .popReq   (popReq),
    .pushData (pushData),
    .ovfErr   (ovfErr),
    .unfErr   (unfErr)
  );

  // ##############################
  // return address stack.
  // ##############################

  // stackHold freezes the pointer and the cells.
  pcStack uStack (
    .PCSCLK    (PCSCLK),
    .T_RST     (T_RST),
    .pushReq   (pushReq),
    .popReq    (popReq),
    .stackHold (stackHold),
    .pushData  (pushData),
    .stkStat   (stkStat)
  );

endmodule

//--- hw/pcSequencer.sv
`include "dspSeq_params.svh"

module pcSequencer
  import dspSeqPkg::*;
(
  input  logic             PCSCLK,
  input  logic             T_RST,
  input  logic             cmdValid,
  input  seqCmd_t          cmd,
  input  stkStat_t         stkStat,
  output logic [`PC_W-1:0] pc,
  output logic             pushReq,
  output logic             popReq,
  output logic [`PC_W-1:0] pushData,
  output logic             ovfErr,
  output logic             unfErr
);

  logic [`PC_W-1:0] pcInc;
  logic [`PC_W-1:0] pcNext;
  logic             isCall;
  logic             isRet;
  logic             ovfSet;
  logic             unfSet;

  // ##############################
  // command decode.
  // ##############################

  assign pcInc = pc + 1'b1;

  // return address for a call.
  assign pushData = pcInc;

  assign isCall = cmdValid && (cmd.op == OP_CALL);
  assign isRet  = cmdValid && (cmd.op == OP_RET);

  // the stack blocks bad pushes and pops itself.
  assign pushReq = isCall;
  assign popReq  = isRet;

  // error conditions seen from this side of the stack.
  assign ovfSet = isCall && stkStat.full;
  assign unfSet = isRet && stkStat.empty;

  always_comb begin
    pcNext = pc; // idle cycle holds.
    if (cmdValid) begin
      unique case (cmd.op)
        OP_NEXT: begin
          pcNext = pcInc;
        end
        OP_JUMP: begin
          pcNext = cmd.target;
        end
        OP_CALL: begin
          // target is taken even when the push is dropped.
          pcNext = cmd.target;
        end
        OP_RET: begin
          if (stkStat.empty) begin
            pcNext = pcInc; // nothing to return to.
          end else begin
            pcNext = stkStat.topPc;
          end
        end
      endcase
    end
  end

  // ##############################
  // program counter.
  // ##############################

  always_ff @(posedge PCSCLK or posedge T_RST) begin
    if (T_RST) begin
      pc <= '0;
    end else begin
      pc <= pcNext;
    end
  end

  // ##############################
  // sticky stack errors.
  // ##############################

  // cleared only by reset.
  always_ff @(posedge PCSCLK or posedge T_RST) begin
    if (T_RST) begin
      ovfErr <= 1'b0;
      unfErr <= 1'b0;
    end else begin
      if (ovfSet) begin
        ovfErr <= 1'b1;
      end
      if (unfSet) begin
        unfErr <= 1'b1;
      end
    end
  end

endmodule

//--- hw/pcStack.sv
`include "dspSeq_params.svh"

module pcStack
  import dspSeqPkg::*;
(
  input  logic             PCSCLK,
  input  logic             T_RST,
  input  logic             pushReq,
  input  logic             popReq,
  input  logic             stackHold,
  input  logic [`PC_W-1:0] pushData,
  output stkStat_t         stkStat
);

  // last occupied slot before the stack reports full.
  localparam logic [`STK_AW:0] ptrLast = `STK_DEPTH - 1;

  logic [`STK_AW:0]   ptr;      // top bit set means empty.
  logic [`STK_AW:0]   ptrInc;
  logic [`STK_AW:0]   ptrDec;
  logic               push;
  logic               pop;
  logic               empty;
  logic               full;
  logic               hasOne;
  logic [`PC_W-1:0]   topPc;
  logic [`PC_W-1:0]   belowPc;

  // ##############################
  // request qualification.
  // ##############################

  // overflow and underflow never reach the pointer.
  assign push = pushReq && !full && !stackHold;
  assign pop  = popReq && !empty && !stackHold;

  assign ptrInc = ptr + 1'b1;
  assign ptrDec = ptr - 1'b1;

  // ##############################
  // stack pointer.
  // ##############################

  always_ff @(posedge PCSCLK or posedge T_RST) begin
    if (T_RST) begin
      ptr <= '1; // empty.
    end else if (push) begin
      ptr <= ptrInc;
    end else if (pop) begin
      ptr <= ptrDec;
    end
  end

  // flags decode straight from the pointer.
  assign empty  = ptr[`STK_AW];
  assign full   = (ptr == ptrLast);
  assign hasOne = (ptr == '0);

  // ##############################
  // register file.
  // ##############################

  // write lands one above the current top.
  pcStackRam uRam (
    .PCSCLK     (PCSCLK),
    .we         (push),
    .waddr      (ptrInc[`STK_AW-1:0]),
    .din        (pushData),
    .raddr      (ptr[`STK_AW-1:0]),
    .raddrBelow (ptrDec[`STK_AW-1:0]),
    .topPc      (topPc),
    .belowPc    (belowPc)
  );

  always_comb begin
    stkStat.topPc   = topPc;
    stkStat.belowPc = belowPc;
    stkStat.empty   = empty;
    stkStat.full    = full;
    stkStat.hasOne  = hasOne;
  end

endmodule

//--- hw/pcStackRam.sv
`include "dspSeq_params.svh"

module pcStackRam (
  input  logic              PCSCLK,
  input  logic              we,
  input  logic [`STK_AW-1:0] waddr,
  input  logic [`PC_W-1:0]  din,
  input  logic [`STK_AW-1:0] raddr,
  input  logic [`STK_AW-1:0] raddrBelow,
  output logic [`PC_W-1:0]  topPc,
  output logic [`PC_W-1:0]  belowPc
);

  // ##############################
  // storage cells.
  // ##############################

  logic [`PC_W-1:0] cells [`STK_DEPTH];

  // single write port on the stack clock.
  always_ff @(posedge PCSCLK) begin
    if (we) begin
      cells[waddr] <= din;
    end
  end

  // ##############################
  // read ports.
  // ##############################

  // both ports are combinational, so they track the pointer directly.
  always_comb begin
    topPc = cells[raddr];
  end

  always_comb begin
    belowPc = cells[raddrBelow]; // next entry down.
  end

endmodule

//--- tb.f
+incdir+hw
+incdir+dv
hw/dspSeqPkg.sv
hw/pcStackRam.sv
hw/pcStack.sv
hw/pcSequencer.sv
hw/pcSeqTop.sv
dv/pcSeqTb.sv
